// File: bench/tb_fetch_frontend.sv
/*
 * testbench for the fetch frontend with a one-cycle cache model and program image
 * random decode back-pressure, backend redirects and assertion checks
 */
`timescale 1ns/1ns

module tb_fetch_frontend;

  localparam logic [31:0] BOOT_ADDR   = 32'h0000_1000;
  // addi x0, x0, 0
  localparam logic [31:0] NOP         = 32'h0000_0013;
  // six tests of at most 300 cycles each, plus reset and drain
  localparam int          TEST_BUDGET = 300;
  localparam int          MAX_CYCLES  = 6 * TEST_BUDGET + 200;

  logic        clk_i;
  logic        rst_ni;
  logic [31:0] boot_addr_i;
  logic        fetch_req_o;
  logic [31:0] fetch_addr_o;
  logic        fetch_ready_i;
  logic        fetch_rvalid_i;
  logic [63:0] fetch_rdata_i;
  logic        fetch_valid_o;
  logic [31:0] fetch_pc_o;
  logic [63:0] fetch_instr_o;
  logic [1:0]  fetch_slot_valid_o;
  logic        fetch_taken_o;
  logic [31:0] fetch_target_o;
  logic        resolve_valid_i;
  logic [31:0] resolve_target_i;

  // program image keyed by byte address
  logic [31:0] image [logic [31:0]];
  // expected prediction per block of the 256-byte program window
  logic        taken_tab  [32];
  logic [31:0] target_tab [32];
  logic        win0_tab   [32];

  logic        consume;
  logic        in_window;
  logic        exp_taken;
  logic [31:0] exp_target;
  logic        exp_win0;
  // both slot words of the block at the head, taken from the image
  logic [63:0] exp_instr;
  // next block decode should see, and whether its slot 0 executes
  logic [31:0] exp_pc;
  logic        exp_slot0;
  logic        seen_fetch;
  int          errors;
  int          cycles;
  int          tests_run;
  int          tests_failed;

  assign consume    = fetch_valid_o && fetch_ready_i;
  assign in_window  = (fetch_pc_o[31:8] == BOOT_ADDR[31:8]);
  assign exp_taken  = in_window && taken_tab[fetch_pc_o[7:3]];
  assign exp_target = target_tab[fetch_pc_o[7:3]];
  assign exp_win0   = in_window && win0_tab[fetch_pc_o[7:3]];
  assign exp_instr  = {read_word(fetch_pc_o + 32'd4), read_word(fetch_pc_o)};

  fetch_frontend i_fetch_frontend (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .boot_addr_i        (boot_addr_i),
    .fetch_req_o        (fetch_req_o),
    .fetch_addr_o       (fetch_addr_o),
    .fetch_ready_i      (fetch_ready_i),
    .fetch_rvalid_i     (fetch_rvalid_i),
    .fetch_rdata_i      (fetch_rdata_i),
    .fetch_valid_o      (fetch_valid_o),
    .fetch_pc_o         (fetch_pc_o),
    .fetch_instr_o      (fetch_instr_o),
    .fetch_slot_valid_o (fetch_slot_valid_o),
    .fetch_taken_o      (fetch_taken_o),
    .fetch_target_o     (fetch_target_o),
    .resolve_valid_i    (resolve_valid_i),
    .resolve_target_i   (resolve_target_i)
  );

  always #10 clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // instruction encoders and image access
  // --------------------------------------------------------------------------
  function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [31:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // bne rs1, rs2, off
  function automatic logic [31:0] enc_bne(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [31:0] off);
    return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b1100111};
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    return image.exists(addr) ? image[addr] : NOP;
  endfunction

  // writes both slots of a block and the prediction decode should get for it
  task automatic place_block(input logic [31:0] addr, input logic [31:0] w0,
                             input logic [31:0] w1, input logic taken,
                             input logic [31:0] target, input logic win0);
    image[addr]           = w0;
    image[addr + 4]       = w1;
    taken_tab[addr[7:3]]  = taken;
    target_tab[addr[7:3]] = target;
    win0_tab[addr[7:3]]   = win0;
  endtask

  task automatic load_program();
    for (int i = 0; i < 32; i++) begin
      taken_tab[i]  = 1'b0;
      target_tab[i] = '0;
      win0_tab[i]   = 1'b0;
    end
    // jal in slot 0 to a target with bit 2 set
    place_block(32'h1050, enc_jal(5'd0, 32'h14), NOP, 1'b1, 32'h1064, 1'b1);
    // forward bne is not taken, backward bne loops to 0x1080
    place_block(32'h1080, NOP, enc_bne(5'd3, 5'd4, 32'h10), 1'b0, '0, 1'b0);
    place_block(32'h1090, enc_bne(5'd3, 5'd4, -32'sd16), NOP, 1'b1, 32'h1080, 1'b1);
    // return reached with an empty stack
    place_block(32'h10a0, enc_jalr(5'd0, 5'd1, '0), NOP, 1'b0, '0, 1'b0);
    // call from 0x10e4 to a return at 0x10d0
    place_block(32'h10d0, enc_jalr(5'd0, 5'd1, '0), NOP, 1'b1, 32'h10e8, 1'b1);
    place_block(32'h10e0, NOP, enc_jal(5'd1, -32'sd20), 1'b1, 32'h10d0, 1'b0);
  endtask

  // --------------------------------------------------------------------------
  // cache model and decode ready
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin : cache_model
    logic        accept;
    logic [31:0] addr;
    accept = fetch_req_o && fetch_ready_i;
    addr   = fetch_addr_o;
    #2;
    fetch_ready_i  <= (($urandom % 4) != 0);
    fetch_rvalid_i <= accept;
    fetch_rdata_i  <= accept ? {read_word(addr + 4), read_word(addr)} : '0;
  end

  // expected block order, mispredict over taken over sequential
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exp_pc     <= {BOOT_ADDR[31:3], 3'b000};
      exp_slot0  <= !BOOT_ADDR[2];
      seen_fetch <= 1'b0;
    end else begin
      if (fetch_req_o && fetch_ready_i) begin
        seen_fetch <= 1'b1;
      end
      if (resolve_valid_i) begin
        exp_pc    <= {resolve_target_i[31:3], 3'b000};
        exp_slot0 <= !resolve_target_i[2];
      end else if (consume && exp_taken) begin
        exp_pc    <= {exp_target[31:3], 3'b000};
        exp_slot0 <= !exp_target[2];
      end else if (consume) begin
        exp_pc    <= exp_pc + 32'd8;
        exp_slot0 <= 1'b1;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------
  a_reset: assert property (@(posedge clk_i) !rst_ni |-> (!fetch_req_o && !fetch_valid_o))
    else begin
      $display("Fail fetch_req_o %h fetch_valid_o %h in reset, expected 0",
               $sampled(fetch_req_o), $sampled(fetch_valid_o));
      errors++;
    end

  a_first: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fetch_req_o && fetch_ready_i && !seen_fetch) |-> fetch_addr_o == {BOOT_ADDR[31:3], 3'b0})
    else begin
      $display("Fail fetch_addr_o: got %h expected %h", $sampled(fetch_addr_o),
               {BOOT_ADDR[31:3], 3'b000});
      errors++;
    end

  a_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    consume |-> fetch_pc_o == exp_pc)
    else begin
      $display("Fail fetch_pc_o: got %h expected %h", $sampled(fetch_pc_o), $sampled(exp_pc));
      errors++;
    end

  a_slot0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    consume |-> fetch_slot_valid_o[0] == exp_slot0)
    else begin
      $display("Fail fetch_slot_valid_o[0]: got %h expected %h",
               $sampled(fetch_slot_valid_o[0]), $sampled(exp_slot0));
      errors++;
    end

  // delivered words match the program image at the block address
  a_instr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    consume |-> fetch_instr_o == exp_instr)
    else begin
      $display("Fail fetch_instr_o at %h: got %h expected %h", $sampled(fetch_pc_o),
               $sampled(fetch_instr_o), $sampled(exp_instr));
      errors++;
    end

  // stalled decode sees a frozen block
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fetch_valid_o && !fetch_ready_i && !resolve_valid_i) |=>
      (fetch_valid_o && $stable(fetch_pc_o) && $stable(fetch_instr_o) &&
       $stable(fetch_slot_valid_o) && $stable(fetch_taken_o) && $stable(fetch_target_o)))
    else begin
      $display("Fail fetch_pc_o %h fetch_instr_o %h changed during stall",
               $sampled(fetch_pc_o), $sampled(fetch_instr_o));
      errors++;
    end

  a_taken: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_valid_o |-> fetch_taken_o == exp_taken)
    else begin
      $display("Fail fetch_taken_o at %h: got %h expected %h", $sampled(fetch_pc_o),
               $sampled(fetch_taken_o), $sampled(exp_taken));
      errors++;
    end

  a_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fetch_valid_o && exp_taken) |-> fetch_target_o == exp_target)
    else begin
      $display("Fail fetch_target_o: got %h expected %h", $sampled(fetch_target_o),
               $sampled(exp_target));
      errors++;
    end

  // slot 1 hidden behind a taken slot 0
  a_mask: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fetch_valid_o && exp_win0) |-> fetch_slot_valid_o == 2'b01)
    else begin
      $display("Fail fetch_slot_valid_o: got %h expected 1", $sampled(fetch_slot_valid_o));
      errors++;
    end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  task automatic redirect(input logic [31:0] target);
    @(posedge clk_i);
    #2;
    resolve_valid_i  = 1'b1;
    resolve_target_i = target;
    @(posedge clk_i);
    #2;
    resolve_valid_i  = 1'b0;
  endtask

  // sampled mid-cycle, returns just before the consuming edge
  task automatic wait_block(input logic [31:0] addr, input int times);
    int hits;
    hits = 0;
    while (hits < times) begin
      @(negedge clk_i);
      if (consume && fetch_pc_o == addr) begin
        hits++;
      end
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_start);
    end
  endtask

  initial begin
    int err_start;
    void'($urandom(32'h924a_8533));
    clk_i            = 1'b0;
    rst_ni           = 1'b1;
    boot_addr_i      = BOOT_ADDR;
    fetch_ready_i    = 1'b0;
    fetch_rvalid_i   = 1'b0;
    fetch_rdata_i    = '0;
    resolve_valid_i  = 1'b0;
    resolve_target_i = '0;
    errors           = 0;
    cycles           = 0;
    tests_run        = 0;
    tests_failed     = 0;
    load_program();
    // falling edge applies the asynchronous reset
    #1;
    rst_ni = 1'b0;
    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    err_start = errors;
    wait_block(BOOT_ADDR, 1);
    report_test("reset and first fetch", err_start);
    err_start = errors;
    wait_block(32'h1030, 1);
    report_test("sequential flow and back-pressure", err_start);
    err_start = errors;
    redirect(32'h1050);
    wait_block(32'h1060, 1);
    report_test("jal", err_start);
    err_start = errors;
    // entry plus one trip round the backward branch
    redirect(32'h1080);
    wait_block(32'h1080, 2);
    report_test("static branches", err_start);
    err_start = errors;
    redirect(32'h10a0);
    wait_block(32'h10a8, 1);
    redirect(32'h10e0);
    wait_block(32'h10e8, 1);
    report_test("call and return", err_start);
    err_start = errors;
    redirect(32'h1034);
    wait_block(32'h1030, 1);
    report_test("mispredict", err_start);

    repeat (2) @(posedge clk_i);
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: compile.f
hw/fetch_pkg.sv
hw/instr_scan.sv
hw/return_stack.sv
hw/branch_predict.sv
hw/fetch_buffer.sv
hw/pc_gen.sv
hw/fetch_frontend.sv
bench/tb_fetch_frontend.sv

// File: hw/branch_predict.sv
/*
 * static control-flow prediction for the block at the head of the buffer
 * selects the winning slot, forms its target and drives the return stack
 */
`timescale 1ns/1ns

module branch_predict (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          flush_i,
  input  logic [fetch_pkg::ADDR_W-1:0]                  block_pc_i,
  input  fetch_pkg::cf_kind_e [fetch_pkg::SLOTS-1:0]    cf_kind_i,
  input  logic [fetch_pkg::SLOTS-1:0]                   is_call_i,
  input  logic [fetch_pkg::SLOTS-1:0][fetch_pkg::ADDR_W-1:0] offset_i,
  input  logic                                          consumed_i,
  output logic                                          predict_taken_o,
  output logic [fetch_pkg::ADDR_W-1:0]                  predict_target_o,
  output logic [fetch_pkg::SLOTS-1:0]                   mask_o
);

  logic                         ras_push;
  logic                         ras_pop;
  logic                         ras_valid;
  logic [fetch_pkg::ADDR_W-1:0] ras_data;
  logic [fetch_pkg::ADDR_W-1:0] ras_top;
  logic [fetch_pkg::ADDR_W-1:0] slot_pc;
  logic                         found;
  logic                         scan;
  logic                         take;

  // --------------------------------------------------------------------------
  // slot selection, lowest slot wins
  // --------------------------------------------------------------------------
  always_comb begin
    predict_taken_o  = 1'b0;
    predict_target_o = '0;
    mask_o           = '1;
    ras_push         = 1'b0;
    ras_pop          = 1'b0;
    ras_data         = '0;
    slot_pc          = block_pc_i;
    found            = 1'b0;
    scan             = 1'b1;
    take             = 1'b0;
    for (int i = 0; i < fetch_pkg::SLOTS; i++) begin
      slot_pc = block_pc_i + (i * fetch_pkg::INSTR_BYTES);
      take    = 1'b0;
      if (found) begin
        // wrong path behind a taken control flow
        mask_o[i] = 1'b0;
      end else if (scan) begin
        // link address of a call, stack only changes when decode takes the block
        if (is_call_i[i]) begin
          ras_push = consumed_i;
          ras_data = slot_pc + fetch_pkg::INSTR_BYTES;
        end
        case (cf_kind_i[i])
          fetch_pkg::CF_JUMP:   take = 1'b1;
          // backward taken, forward not taken
          fetch_pkg::CF_BRANCH: take = offset_i[i][fetch_pkg::ADDR_W-1];
          fetch_pkg::CF_RETURN: begin
            take = ras_valid;
            scan = ras_valid;
          end
          // unpredicted indirect jump, later slots are left to the backend
          fetch_pkg::CF_JALR:   scan = 1'b0;
          default: ;
        endcase
        if (take) begin
          found           = 1'b1;
          predict_taken_o = 1'b1;
          if (cf_kind_i[i] == fetch_pkg::CF_RETURN) begin
            predict_target_o = ras_top;
            ras_pop          = consumed_i;
          end else begin
            predict_target_o = slot_pc + offset_i[i];
          end
        end
      end
    end
  end

  return_stack #(
    .Depth (fetch_pkg::RAS_DEPTH)
  ) i_return_stack (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .push_i      (ras_push),
    .pop_i       (ras_pop),
    .data_i      (ras_data),
    .top_valid_o (ras_valid),
    .top_o       (ras_top)
  );

endmodule

// File: hw/fetch_buffer.sv
/*
 * in-flight request tracking and two-entry queue of fetched blocks
 * derives slot validity from the request address
 */
`timescale 1ns/1ns

module fetch_buffer (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            req_accept_i,
  input  logic [fetch_pkg::ADDR_W-1:0]    req_addr_i,
  input  logic                            rvalid_i,
  input  logic [fetch_pkg::BLOCK_W-1:0]   rdata_i,
  input  logic                            buf_flush_i,
  input  logic                            buf_flush_head_i,
  input  logic                            decode_ready_i,
  output logic [fetch_pkg::BUF_CNT_W-1:0] buf_space_o,
  output logic                            block_consumed_o,
  output logic                            valid_o,
  output logic [fetch_pkg::ADDR_W-1:0]    pc_o,
  output logic [fetch_pkg::BLOCK_W-1:0]   instr_o,
  output logic [fetch_pkg::SLOTS-1:0]     slot_valid_o
);

  // in-flight request, the cache answers one cycle after acceptance
  logic                                     inflight_q;
  logic                                     kill_q;
  logic [fetch_pkg::ADDR_W-1:0]             inflight_addr_q;

  // block queue
  logic [fetch_pkg::ADDR_W-1:0]             pc_q   [fetch_pkg::BUF_DEPTH];
  logic [fetch_pkg::BLOCK_W-1:0]            data_q [fetch_pkg::BUF_DEPTH];
  logic [fetch_pkg::SLOTS-1:0]              sv_q   [fetch_pkg::BUF_DEPTH];
  logic [fetch_pkg::BUF_CNT_W-1:0]          count_q;
  logic [$clog2(fetch_pkg::BUF_DEPTH)-1:0]  rd_ptr_q;
  logic [$clog2(fetch_pkg::BUF_DEPTH)-1:0]  wr_ptr;
  logic                                     wr_en;
  logic [$clog2(fetch_pkg::SLOTS)-1:0]      first_slot;
  logic [fetch_pkg::SLOTS-1:0]              new_sv;

  // drop a response that is killed or arrives during a redirect
  assign wr_en  = rvalid_i && inflight_q && !kill_q && !buf_flush_i;
  assign wr_ptr = rd_ptr_q + count_q[$clog2(fetch_pkg::BUF_DEPTH)-1:0];

  // slots below the entry point of the request are not executed
  assign first_slot = inflight_addr_q[fetch_pkg::BLOCK_OFFSET_BITS-1 -: $clog2(fetch_pkg::SLOTS)];
  always_comb begin
    for (int i = 0; i < fetch_pkg::SLOTS; i++) begin
      new_sv[i] = (i >= int'(first_slot));
    end
  end

  assign valid_o          = (count_q != '0);
  assign block_consumed_o = valid_o && decode_ready_i;
  assign pc_o             = pc_q[rd_ptr_q];
  assign instr_o          = data_q[rd_ptr_q];
  assign slot_valid_o     = valid_o ? sv_q[rd_ptr_q] : '0;
  assign buf_space_o      = count_q + inflight_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= 1'b0;
      kill_q     <= 1'b0;
      count_q    <= '0;
      rd_ptr_q   <= '0;
    end else begin
      inflight_q <= req_accept_i;
      // a request accepted during a redirect belongs to the old stream
      kill_q     <= req_accept_i && buf_flush_i;
      if (block_consumed_o) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (buf_flush_i) begin
        // everything behind the head goes, the head only on a full flush
        if (buf_flush_head_i || block_consumed_o || !valid_o) begin
          count_q <= '0;
        end else begin
          count_q <= 1'b1;
        end
      end else begin
        count_q <= count_q + wr_en - block_consumed_o;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_accept_i) begin
      inflight_addr_q <= req_addr_i;
    end
    if (wr_en) begin
      pc_q[wr_ptr]   <= {inflight_addr_q[fetch_pkg::ADDR_W-1:fetch_pkg::BLOCK_OFFSET_BITS],
                         {fetch_pkg::BLOCK_OFFSET_BITS{1'b0}}};
      data_q[wr_ptr] <= rdata_i;
      sv_q[wr_ptr]   <= new_sv;
    end
  end

  // requests are throttled in pc_gen so every response finds a free entry
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> (count_q < fetch_pkg::BUF_DEPTH))
    else $error("fetch response while the block queue is full");

endmodule

// File: hw/fetch_frontend.sv
/*
 * instruction fetch frontend top level
 * PC generation, block buffer, slot scanners and static prediction
 */
`timescale 1ns/1ns

module fetch_frontend (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [fetch_pkg::ADDR_W-1:0]  boot_addr_i,
  // cache side, the ready is shared with decode
  output logic                          fetch_req_o,
  output logic [fetch_pkg::ADDR_W-1:0]  fetch_addr_o,
  input  logic                          fetch_ready_i,
  input  logic                          fetch_rvalid_i,
  input  logic [fetch_pkg::BLOCK_W-1:0] fetch_rdata_i,
  // decode side
  output logic                          fetch_valid_o,
  output logic [fetch_pkg::ADDR_W-1:0]  fetch_pc_o,
  output logic [fetch_pkg::BLOCK_W-1:0] fetch_instr_o,
  output logic [fetch_pkg::SLOTS-1:0]   fetch_slot_valid_o,
  output logic                          fetch_taken_o,
  output logic [fetch_pkg::ADDR_W-1:0]  fetch_target_o,
  // backend mispredict
  input  logic                          resolve_valid_i,
  input  logic [fetch_pkg::ADDR_W-1:0]  resolve_target_i
);

  logic [fetch_pkg::ADDR_W-1:0]                       req_pc;
  logic                                               req_accept;
  logic [fetch_pkg::BUF_CNT_W-1:0]                    buf_space;
  logic                                               buf_flush;
  logic                                               buf_flush_head;
  logic                                               block_consumed;
  logic [fetch_pkg::SLOTS-1:0]                        buf_slot_valid;
  logic [fetch_pkg::SLOTS-1:0]                        predict_mask;
  fetch_pkg::cf_kind_e [fetch_pkg::SLOTS-1:0]         cf_kind;
  logic [fetch_pkg::SLOTS-1:0]                        is_call;
  logic [fetch_pkg::SLOTS-1:0][fetch_pkg::ADDR_W-1:0] offset;

  assign req_accept         = fetch_req_o && fetch_ready_i;
  // slots behind a taken control flow are hidden from decode
  assign fetch_slot_valid_o = buf_slot_valid & predict_mask;

  pc_gen i_pc_gen (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .boot_addr_i      (boot_addr_i),
    .fetch_ready_i    (fetch_ready_i),
    .buf_space_i      (buf_space),
    .block_consumed_i (block_consumed),
    .predict_taken_i  (fetch_taken_o),
    .predict_target_i (fetch_target_o),
    .resolve_valid_i  (resolve_valid_i),
    .resolve_target_i (resolve_target_i),
    .fetch_req_o      (fetch_req_o),
    .fetch_addr_o     (fetch_addr_o),
    .req_pc_o         (req_pc),
    .buf_flush_o      (buf_flush),
    .buf_flush_head_o (buf_flush_head)
  );

  fetch_buffer i_fetch_buffer (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_accept_i     (req_accept),
    .req_addr_i       (req_pc),
    .rvalid_i         (fetch_rvalid_i),
    .rdata_i          (fetch_rdata_i),
    .buf_flush_i      (buf_flush),
    .buf_flush_head_i (buf_flush_head),
    .decode_ready_i   (fetch_ready_i),
    .buf_space_o      (buf_space),
    .block_consumed_o (block_consumed),
    .valid_o          (fetch_valid_o),
    .pc_o             (fetch_pc_o),
    .instr_o          (fetch_instr_o),
    .slot_valid_o     (buf_slot_valid)
  );

  // one scanner per slot, slot 0 in the low word
  for (genvar g = 0; g < fetch_pkg::SLOTS; g++) begin : gen_scan
    instr_scan i_instr_scan (
      .instr_i      (fetch_instr_o[g*fetch_pkg::INSTR_W +: fetch_pkg::INSTR_W]),
      .slot_valid_i (buf_slot_valid[g]),
      .cf_kind_o    (cf_kind[g]),
      .is_call_o    (is_call[g]),
      .offset_o     (offset[g])
    );
  end

  branch_predict i_branch_predict (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (buf_flush_head),
    .block_pc_i       (fetch_pc_o),
    .cf_kind_i        (cf_kind),
    .is_call_i        (is_call),
    .offset_i         (offset),
    .consumed_i       (block_consumed),
    .predict_taken_o  (fetch_taken_o),
    .predict_target_o (fetch_target_o),
    .mask_o           (predict_mask)
  );

endmodule

// File: hw/fetch_pkg.sv
/*
 * shared widths and sizes of the instruction fetch frontend
 * RISC-V opcode and control-flow kind encodings
 */
package fetch_pkg;

  // --------------------------------------------------------------------------
  // datapath widths
  // --------------------------------------------------------------------------
  localparam int unsigned ADDR_W            = 32;
  localparam int unsigned INSTR_W           = 32;
  // one fetch block holds two uncompressed instructions
  localparam int unsigned SLOTS             = 2;
  localparam int unsigned BLOCK_W           = 64;
  localparam int unsigned BLOCK_OFFSET_BITS = 3;
  localparam int unsigned INSTR_BYTES       = 4;

  // --------------------------------------------------------------------------
  // storage sizes
  // --------------------------------------------------------------------------
  localparam int unsigned RAS_DEPTH = 4;
  localparam int unsigned BUF_DEPTH = 2;
  // occupancy counter, queued blocks plus the in-flight request
  localparam int unsigned BUF_CNT_W = $clog2(BUF_DEPTH + 1);

  // link registers ra and t0, used for call and return detection
  localparam logic [4:0] REG_RA = 5'd1;
  localparam logic [4:0] REG_T0 = 5'd5;

  // major opcodes that change control flow, all others are ordinary
  typedef enum logic [6:0] {
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111
  } rv_opcode_e;

  // control-flow kind reported by the scanner for one slot
  typedef enum logic [2:0] {
    CF_NONE,
    CF_BRANCH,
    CF_JUMP,
    CF_JALR,
    CF_RETURN
  } cf_kind_e;

endpackage

// File: hw/instr_scan.sv
/*
 * pre-decoder for one 32-bit instruction slot
 * reports control-flow kind, call flag and immediate offset
 */
`timescale 1ns/1ns

module instr_scan (
  input  logic [fetch_pkg::INSTR_W-1:0] instr_i,
  input  logic                          slot_valid_i,
  output fetch_pkg::cf_kind_e           cf_kind_o,
  output logic                          is_call_o,
  output logic [fetch_pkg::ADDR_W-1:0]  offset_o
);

  fetch_pkg::rv_opcode_e            opcode;
  logic [4:0]                       rd;
  logic [4:0]                       rs1;
  logic                             rd_link;
  logic                             rs1_link;
  logic [fetch_pkg::ADDR_W-1:0]     imm_b;
  logic [fetch_pkg::ADDR_W-1:0]     imm_j;
  logic [fetch_pkg::ADDR_W-1:0]     imm_i;

  assign opcode = fetch_pkg::rv_opcode_e'(instr_i[6:0]);
  assign rd     = instr_i[11:7];
  assign rs1    = instr_i[19:15];

  // ra and t0 both count as link registers
  assign rd_link  = (rd == fetch_pkg::REG_RA) || (rd == fetch_pkg::REG_T0);
  assign rs1_link = (rs1 == fetch_pkg::REG_RA) || (rs1 == fetch_pkg::REG_T0);

  // sign-extended immediates, B and J types are in units of two bytes
  assign imm_b = {{(fetch_pkg::ADDR_W - 12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_j = {{(fetch_pkg::ADDR_W - 20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};
  assign imm_i = {{(fetch_pkg::ADDR_W - 12){instr_i[31]}}, instr_i[31:20]};

  always_comb begin
    cf_kind_o = fetch_pkg::CF_NONE;
    is_call_o = 1'b0;
    offset_o  = '0;
    // an empty slot never reports control flow
    if (slot_valid_i) begin
      case (opcode)
        fetch_pkg::OPC_BRANCH: begin
          cf_kind_o = fetch_pkg::CF_BRANCH;
          offset_o  = imm_b;
        end
        fetch_pkg::OPC_JAL: begin
          cf_kind_o = fetch_pkg::CF_JUMP;
          is_call_o = rd_link;
          offset_o  = imm_j;
        end
        fetch_pkg::OPC_JALR: begin
          is_call_o = rd_link;
          offset_o  = imm_i;
          // jalr x0, 0(ra) or 0(t0) is a function return
          if (rd == 5'd0 && rs1_link) begin
            cf_kind_o = fetch_pkg::CF_RETURN;
          end else begin
            cf_kind_o = fetch_pkg::CF_JALR;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

// File: hw/pc_gen.sv
/*
 * next-PC register, redirect priority and fetch request generation
 */
`timescale 1ns/1ns

module pc_gen (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [fetch_pkg::ADDR_W-1:0]    boot_addr_i,
  input  logic                            fetch_ready_i,
  input  logic [fetch_pkg::BUF_CNT_W-1:0] buf_space_i,
  input  logic                            block_consumed_i,
  input  logic                            predict_taken_i,
  input  logic [fetch_pkg::ADDR_W-1:0]    predict_target_i,
  input  logic                            resolve_valid_i,
  input  logic [fetch_pkg::ADDR_W-1:0]    resolve_target_i,
  output logic                            fetch_req_o,
  output logic [fetch_pkg::ADDR_W-1:0]    fetch_addr_o,
  output logic [fetch_pkg::ADDR_W-1:0]    req_pc_o,
  output logic                            buf_flush_o,
  output logic                            buf_flush_head_o
);

  // npc_q keeps the exact target so that the buffer can mask leading slots
  logic [fetch_pkg::ADDR_W-1:0] npc_q;
  logic [fetch_pkg::ADDR_W-1:0] npc_d;
  // boot address not yet loaded
  logic                         boot_load_q;
  logic                         req_accept;
  logic                         taken_redirect;

  assign fetch_addr_o = {npc_q[fetch_pkg::ADDR_W-1:fetch_pkg::BLOCK_OFFSET_BITS],
                         {fetch_pkg::BLOCK_OFFSET_BITS{1'b0}}};
  assign req_pc_o     = npc_q;

  // request while queued blocks plus the in-flight one leave room
  assign fetch_req_o = !boot_load_q && (buf_space_i < fetch_pkg::BUF_DEPTH);
  assign req_accept  = fetch_req_o && fetch_ready_i;

  // a predicted-taken block redirects when decode takes it
  assign taken_redirect   = block_consumed_i && predict_taken_i;
  assign buf_flush_o      = resolve_valid_i || taken_redirect;
  assign buf_flush_head_o = resolve_valid_i;

  // --------------------------------------------------------------------------
  // next PC, mispredict over prediction over sequential
  // --------------------------------------------------------------------------
  always_comb begin
    npc_d = npc_q;
    if (boot_load_q) begin
      npc_d = boot_addr_i;
    end else if (req_accept) begin
      npc_d = fetch_addr_o + (fetch_pkg::SLOTS * fetch_pkg::INSTR_BYTES);
    end
    if (resolve_valid_i) begin
      npc_d = resolve_target_i;
    end else if (taken_redirect) begin
      npc_d = predict_target_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      npc_q       <= '0;
      boot_load_q <= 1'b1;
    end else begin
      npc_q       <= npc_d;
      boot_load_q <= 1'b0;
    end
  end

  // without a redirect, fetch walks forward one aligned block per request
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_accept && !buf_flush_o) |=>
      (fetch_addr_o == $past(fetch_addr_o) + (fetch_pkg::SLOTS * fetch_pkg::INSTR_BYTES)))
    else $error("fetch address did not advance by one block");

endmodule

// File: hw/return_stack.sv
/*
 * circular return address stack with push, pop and flush
 */
`timescale 1ns/1ns

module return_stack #(
  parameter int unsigned Depth = fetch_pkg::RAS_DEPTH
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  input  logic                         push_i,
  input  logic                         pop_i,
  input  logic [fetch_pkg::ADDR_W-1:0] data_i,
  output logic                         top_valid_o,
  output logic [fetch_pkg::ADDR_W-1:0] top_o
);

  logic [fetch_pkg::ADDR_W-1:0] stack_q [Depth];
  // ptr_q points at the next free entry
  logic [$clog2(Depth)-1:0]     ptr_q;
  logic [$clog2(Depth)-1:0]     next_idx;
  logic [$clog2(Depth)-1:0]     top_idx;
  logic [$clog2(Depth+1)-1:0]   cnt_q;

  // pointer arithmetic wraps around for any depth
  assign next_idx = (ptr_q == $clog2(Depth)'(Depth - 1)) ? '0 : ptr_q + 1'b1;
  assign top_idx  = (ptr_q == '0) ? $clog2(Depth)'(Depth - 1) : ptr_q - 1'b1;

  assign top_valid_o = (cnt_q != '0);
  assign top_o       = stack_q[top_idx];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
      cnt_q <= '0;
    end else if (flush_i) begin
      ptr_q <= '0;
      cnt_q <= '0;
    end else if (push_i) begin
      ptr_q <= next_idx;
      // when full the oldest entry is overwritten, count saturates
      if (cnt_q != $clog2(Depth+1)'(Depth)) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end else if (pop_i && top_valid_o) begin
      ptr_q <= top_idx;
      cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i && !flush_i) begin
      stack_q[ptr_q] <= data_i;
    end
  end

  // the predictor only ever acts on one winning slot per block
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_i && pop_i))
    else $error("return stack push and pop in the same cycle");

endmodule

// File: run.sh
#!/usr/bin/env bash
# build the fetch frontend testbench with Verilator, run it, search the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_fetch_frontend --Mdir obj_dir -o sim_fetch_frontend
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_fetch_frontend > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
  exit 0
fi
exit 1
